// ==== rtl/eth_crc_pkg.sv ====
// CRC-32 constants for the Ethernet FCS
// Byte-wise reflected CRC-32 update function, LSB first
package eth_crc_pkg;

    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320; // Bit-reversed form of 0x04C11DB7
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF; // Start value of every frame

    // One data byte through the shift register, bit 0 of the byte first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] state,
        input logic [7:0]  data
    );
        logic [31:0] crc;
        crc = state;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ CRC_POLY; // Feedback bit set so fold in the polynomial
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

endpackage

// ==== rtl/eth_frame_pkg.sv ====
// Ethernet frame size constants
// State types of the pad inserter and the FCS appender
package eth_frame_pkg;

    localparam logic [6:0] MIN_FRAME_BYTES = 7'd60; // Shortest frame without the FCS
    localparam int         FCS_BYTES       = 4;     // Length of the appended CRC

    // Pad inserter states
    typedef enum logic {
        PAD_DATA, // Frame bytes pass straight through
        PAD_FILL  // Zero bytes are generated up to the minimum length
    } pad_state_e;

    // FCS appender states
    typedef enum logic [1:0] {
        APP_PASS,     // Frame bytes go to the output register
        APP_WAIT_FCS, // Last byte taken, the CRC arrives next cycle
        APP_FCS       // The four FCS bytes are shifted out
    } append_state_e;

endpackage

// ==== rtl/byte_stream_if.sv ====
// Byte-wide stream between the blocks of the transmit FCS path
// Valid/ready handshake with a last flag on the final byte of a frame
`timescale 1ns/1ps

interface byte_stream_if;

    logic [7:0] data;  // Payload byte
    logic       valid; // Source has a byte on data
    logic       last;  // Byte closes the frame
    logic       ready; // Sink takes the byte this cycle

    modport src (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport snk (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

// ==== rtl/eth_ingress_fifo.sv ====
// Ingress FIFO of the transmit FCS path
// Takes bytes from a credit-controlled upstream and returns one credit per pop
// Presents the buffered bytes as a valid/ready stream
`timescale 1ns/1ps

module eth_ingress_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   in_data,
    input  logic         in_valid,
    input  logic         in_last,
    output logic         in_credit,
    byte_stream_if.src   out
);

    localparam int AW = $clog2(FIFO_DEPTH); // Pointer width, depth is a power of two

    logic [7:0]  mem_data [FIFO_DEPTH]; // Buffered bytes
    logic        mem_last [FIFO_DEPTH]; // End of frame flag per entry
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;               // Entries held, up to FIFO_DEPTH
    logic          push;
    logic          pop;

    // The sender only transmits with credit, so a push always finds room
    assign push = in_valid;
    assign pop  = out.valid && out.ready;

    // Head of the buffer, written at least one cycle earlier
    assign out.valid = (count != '0);
    assign out.data  = mem_data[rd_ptr];
    assign out.last  = mem_last[rd_ptr];

    // Each entry that leaves frees one slot upstream
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at FIFO_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither leave the level alone
            endcase
        end
    end

endmodule

// ==== rtl/eth_pad_insert.sv ====
// Pad inserter of the transmit FCS path
// Forwards frame bytes and adds zero bytes to reach the minimum frame length
`timescale 1ns/1ps

module eth_pad_insert import eth_frame_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    byte_stream_if.snk in,
    byte_stream_if.src out
);

    pad_state_e state;
    logic [6:0] byte_cnt; // Bytes of this frame already passed, saturates
    logic       short_last;
    logic       fill_last;
    logic       out_fire;

    // A last byte numbered below 60 opens the fill phase
    assign short_last = in.last && (byte_cnt < MIN_FRAME_BYTES - 7'd1);
    assign fill_last  = (byte_cnt == MIN_FRAME_BYTES - 7'd1); // Next zero byte is byte 60
    assign out_fire   = out.valid && out.ready;

    always_comb begin
        case (state)
            PAD_FILL: begin
                out.valid = 1'b1;      // Pad bytes are always available
                out.data  = 8'h00;
                out.last  = fill_last;
                in.ready  = 1'b0;      // Next frame waits until padding is done
            end
            default: begin
                out.valid = in.valid;  // Pure pass-through, no added latency
                out.data  = in.data;
                out.last  = in.last && !short_last;
                in.ready  = out.ready;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= PAD_DATA;
            byte_cnt <= '0;
        end else if (out_fire) begin
            case (state)
                PAD_DATA: begin
                    if (short_last) begin
                        state    <= PAD_FILL;
                        byte_cnt <= byte_cnt + 7'd1;
                    end else if (in.last) begin
                        byte_cnt <= '0; // Long enough, next byte starts a new frame
                    end else if (byte_cnt != MIN_FRAME_BYTES) begin
                        byte_cnt <= byte_cnt + 7'd1;
                    end
                end
                PAD_FILL: begin
                    if (fill_last) begin
                        state    <= PAD_DATA;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 7'd1;
                    end
                end
                default: state <= PAD_DATA;
            endcase
        end
    end

endmodule

// ==== rtl/eth_fcs_gen.sv ====
// Ethernet FCS generator
// Running reflected CRC-32 over the accepted bytes of a frame
// Presents the inverted CRC for one cycle after the last byte
`timescale 1ns/1ps

module eth_fcs_gen import eth_crc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data,
    input  logic        beat,
    input  logic        last,
    output logic [31:0] fcs,
    output logic        fcs_valid
);

    logic [31:0] crc_state;
    logic [31:0] crc_next;

    assign crc_next = crc32_byte(crc_state, data);

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_state <= CRC_INIT;
            fcs_valid <= 1'b0;
        end else begin
            fcs_valid <= 1'b0; // Single-cycle strobe
            if (beat) begin
                if (last) begin
                    crc_state <= CRC_INIT; // Ready for the next frame at once
                    fcs_valid <= 1'b1;
                end else begin
                    crc_state <= crc_next;
                end
            end
        end
    end

    // Captured value only, consumers look at it under fcs_valid
    always_ff @(posedge clk) begin
        if (beat && last) begin
            fcs <= ~crc_next; // Final inversion of the CRC register
        end
    end

endmodule

// ==== rtl/eth_fcs_append.sv ====
// FCS appender and output stage of the transmit FCS path
// Registers frame bytes to the output and appends the four FCS bytes LSB first
// Sends only while it holds downstream credit
`timescale 1ns/1ps

module eth_fcs_append import eth_frame_pkg::*; #(
    parameter int OUT_CREDITS = 4
) (
    input  logic       clk,
    input  logic       rst,
    byte_stream_if.snk in,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_credit
);

    localparam int CW = $clog2(OUT_CREDITS + 1); // Counter holds 0 to OUT_CREDITS

    append_state_e state;
    logic [CW-1:0] credit_cnt; // Credits not yet spent by an out_valid beat
    logic          can_send;   // A credit is left after the byte now on the output
    logic          in_fire;
    logic [31:0]   fcs;
    logic          fcs_valid;
    logic [31:0]   fcs_shift;  // Remaining FCS bytes, next one in bits 7:0
    logic [1:0]    fcs_cnt;    // Index of the FCS byte to send

    // The byte in the output register spends its credit this cycle
    assign can_send = (credit_cnt > CW'(out_valid));
    assign in.ready = (state == APP_PASS) && can_send;
    assign in_fire  = in.valid && in.ready;

    eth_fcs_gen u_fcs_gen (
        .clk       (clk),
        .rst       (rst),
        .data      (in.data),
        .beat      (in_fire),
        .last      (in.last),
        .fcs       (fcs),
        .fcs_valid (fcs_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CW'(out_credit) - CW'(out_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= APP_PASS;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            fcs_cnt   <= '0;
        end else begin
            out_valid <= 1'b0; // Each output byte shows for one cycle
            out_last  <= 1'b0;
            case (state)
                APP_PASS: begin
                    if (in_fire) begin
                        out_valid <= 1'b1;
                        if (in.last) begin
                            state <= APP_WAIT_FCS;
                        end
                    end
                end
                APP_WAIT_FCS: begin
                    if (fcs_valid) begin
                        state   <= APP_FCS;
                        fcs_cnt <= '0;
                    end
                end
                APP_FCS: begin
                    if (can_send) begin
                        out_valid <= 1'b1;
                        fcs_cnt   <= fcs_cnt + 2'd1;
                        if (fcs_cnt == 2'(FCS_BYTES - 1)) begin
                            out_last <= 1'b1; // Frame ends on the fourth FCS byte
                            state    <= APP_PASS;
                        end
                    end
                end
                default: state <= APP_PASS;
            endcase
        end
    end

    // Payload path, qualified by out_valid and state
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= in.data;
        end else if (state == APP_FCS && can_send) begin
            out_data <= fcs_shift[7:0];
        end
        if (state == APP_WAIT_FCS && fcs_valid) begin
            fcs_shift <= fcs;
        end else if (state == APP_FCS && can_send) begin
            fcs_shift <= {8'h00, fcs_shift[31:8]};
        end
    end

endmodule

// ==== rtl/eth_tx_fcs_top.sv ====
// Transmit FCS stage of the Ethernet MAC byte datapath
// Ingress FIFO, pad inserter and FCS appender in a chain
// Credit-controlled byte streams on both external sides
`timescale 1ns/1ps

module eth_tx_fcs_top #(
    parameter int FIFO_DEPTH  = 16, // Also the upstream's credit after reset
    parameter int OUT_CREDITS = 4   // Downstream credit after reset
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_credit,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_credit
);

    byte_stream_if s_fifo (); // FIFO to pad inserter
    byte_stream_if s_pad  (); // Pad inserter to appender

    eth_ingress_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ingress (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_credit (in_credit),
        .out       (s_fifo.src)
    );

    eth_pad_insert u_pad (
        .clk (clk),
        .rst (rst),
        .in  (s_fifo.snk),
        .out (s_pad.src)
    );

    eth_fcs_append #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_append (
        .clk        (clk),
        .rst        (rst),
        .in         (s_pad.snk),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

endmodule

// ==== testbench/eth_tx_fcs_sva.sv ====
// Assertions bound into the transmit FCS top level
// Downstream credit use, ingress FIFO level and FCS strobe width
`timescale 1ns/1ps

module eth_tx_fcs_sva #(
    parameter int FIFO_DEPTH  = 16,
    parameter int OUT_CREDITS = 4
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               out_valid,
    input logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt, // Appender credit counter
    input logic [$clog2(FIFO_DEPTH):0]        fifo_count, // Ingress FIFO occupancy
    input logic                               fcs_valid
);

    int fail_count = 0; // Read by the testbench at the end of the run

    // A byte on the output always has a credit behind it
    credit_guard: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (credit_cnt != '0))
        else begin
            fail_count++;
            $error("out_valid while the downstream credit counter is zero");
        end

    fifo_bound: assert property (@(posedge clk) disable iff (rst)
        fifo_count <= FIFO_DEPTH) // Sender never overruns the buffer
        else begin
            fail_count++;
            $error("ingress FIFO occupancy above its depth");
        end

    fcs_strobe: assert property (@(posedge clk) disable iff (rst)
        fcs_valid |=> !fcs_valid) // One cycle per frame
        else begin
            fail_count++;
            $error("fcs_valid held for more than one cycle");
        end

endmodule

// ==== testbench/eth_tx_fcs_checker.sv ====
// Checker of the transmit FCS path
// Reference model of zero padding and the reflected CRC-32 FCS
// Byte compare of every output beat, credit accounting and error counts
`timescale 1ns/1ps

module eth_tx_fcs_checker import eth_frame_pkg::*; #(
    parameter int OUT_CREDITS = 4
) (
    input logic       clk,
    input logic       rst,
    input logic [7:0] in_data,
    input logic       in_valid,
    input logic       in_last,
    input logic       in_credit,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_last,
    input logic       out_credit
);

    logic [7:0]  frame_q[$]; // Padded bytes of the frame now entering
    logic [10:0] exp_q[$];   // Expected beats as kind, last and data
    logic        started = 1'b0;
    int mismatch_count = 0;
    int other_count    = 0;
    int frames_in      = 0;
    int frames_out     = 0;
    int in_bytes       = 0;
    int credit_pulses  = 0; // in_credit pulses seen
    int credits_back   = 0; // out_credit pulses seen
    int out_bytes      = 0;
    int out_pos        = 0; // Byte index inside the current output frame

    // MSB-first CRC with the normal polynomial, fed each byte LSB first, then reflected
    function automatic logic [31:0] fcs_model();
        logic [31:0] crc;
        logic [31:0] fcs;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (frame_q[n]) begin
            for (int i = 0; i < 8; i++) begin
                fb  = crc[31] ^ frame_q[n][i];
                crc = {crc[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        for (int i = 0; i < 32; i++) begin
            fcs[i] = ~crc[31 - i]; // Bit reversal and final inversion
        end
        return fcs;
    endfunction

    task automatic report(input string msg);
        other_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_beat(input logic [10:0] exp);
        string name;
        name = (exp[10:9] == 2'd0) ? "frame_data" : (exp[10:9] == 2'd1) ? "zero_pad" : "fcs";
        if (out_data !== exp[7:0] || out_last !== exp[8]) begin
            mismatch_count++;
            $display({"CHECK FAILED %s frame %0d byte %0d: ",
                      "expected %02h last %0b, actual %02h last %0b"},
                     name, frames_out, out_pos, exp[7:0], exp[8], out_data, out_last);
        end
        out_pos++;
        if (out_last === 1'b1) begin
            frames_out++; // Frame boundary as the DUT marks it
            out_pos = 0;
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] fcs;
        if (!rst) begin
            if (!started && (out_valid === 1'b1 || in_credit === 1'b1)) begin
                report("output activity after reset before any input byte");
            end
            credit_pulses += int'(in_credit);
            credits_back  += int'(out_credit);
            if (in_valid) begin
                started = 1'b1;
                in_bytes++;
                frame_q.push_back(in_data);
                exp_q.push_back({2'd0, 1'b0, in_data}); // Data bytes never carry out_last
                if (in_last) begin
                    while (frame_q.size() < MIN_FRAME_BYTES) begin
                        frame_q.push_back(8'h00);
                        exp_q.push_back({2'd1, 1'b0, 8'h00});
                    end
                    fcs = fcs_model();
                    for (int k = 0; k < FCS_BYTES; k++) begin
                        exp_q.push_back({2'd2, (k == FCS_BYTES - 1), fcs[8*k +: 8]}); // LSB first
                    end
                    frame_q.delete();
                    frames_in++;
                end
            end
            if (out_valid === 1'b1) begin
                out_bytes++;
                if (out_bytes > OUT_CREDITS + credits_back) begin
                    report("more output bytes than downstream credits granted");
                end
                if (exp_q.size() == 0) begin
                    report("output byte with no expected byte pending");
                end else begin
                    compare_beat(exp_q.pop_front());
                end
            end
        end
    end

    // End of run accounting, called once by the testbench
    task automatic final_check(input int frames_sent);
        if (frames_in != frames_sent || frames_out != frames_sent) begin
            report($sformatf("%0d frames sent, %0d seen at the input, %0d ended at the output",
                             frames_sent, frames_in, frames_out));
        end
        if (exp_q.size() != 0) begin
            report($sformatf("%0d expected bytes never came out", exp_q.size()));
        end
        if (credit_pulses != in_bytes) begin
            report($sformatf("%0d input bytes accepted but %0d upstream credits returned",
                             in_bytes, credit_pulses));
        end
    endtask

endmodule

// ==== testbench/eth_tx_fcs_tb.sv ====
// Testbench top of the transmit FCS path
// Clock, reset, seeded random frames under upstream credit, random downstream credit
// Watchdog and the closing result line
`timescale 1ns/1ps

module eth_tx_fcs_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FRAMES   = 40;
    localparam int FIFO_DEPTH   = 16; // DUT default, the sender's credit after reset
    localparam int OUT_CREDITS  = 4;  // DUT default downstream credit
    localparam int TIMEOUT_NS   = NUM_FRAMES * 104 * 8 * CLK_PERIOD;

    logic       clk;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_last;
    logic       in_credit;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    logic       out_credit;
    integer     seed;       // Shared $random state
    int         up_credits; // Free FIFO slots as the sender sees them
    int         total_errors;

    eth_tx_fcs_top dut0 (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_credit(in_credit),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_credit(out_credit)
    );

    eth_tx_fcs_checker #(.OUT_CREDITS(OUT_CREDITS)) chk0 (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_credit(in_credit),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_credit(out_credit)
    );

    bind eth_tx_fcs_top eth_tx_fcs_sva #(
        .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)
    ) sva0 (
        .clk(clk), .rst(rst), .out_valid(out_valid),
        .credit_cnt(u_append.credit_cnt), .fifo_count(u_ingress.count),
        .fcs_valid(u_append.fcs_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One byte to the upstream port, waiting for credit and random idle cycles
    task automatic send_byte(input logic [7:0] b, input logic l);
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            @(posedge clk);
            if (in_credit === 1'b1) begin
                up_credits++; // Pop in the cycle just ended
            end
            #2;
            if (up_credits > 0 && $random(seed) % 4 != 0) begin
                in_data  = b;
                in_valid = 1'b1;
                in_last  = l;
                up_credits--;
                sent = 1'b1;
            end else begin
                in_valid = 1'b0;
                in_last  = 1'b0;
            end
        end
    endtask

    initial begin
        int len;
        rst        = 1'b1;
        in_data    = 8'h00;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        out_credit = 1'b0;
        seed       = 32'h05a0_1444;
        up_credits = FIFO_DEPTH;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (12) @(posedge clk); // Idle window where both credit-side outputs must stay low
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len = 1 + int'($unsigned($random(seed)) % 100);
            for (int n = 0; n < len; n++) begin
                send_byte(8'($random(seed)), n == len - 1);
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        in_last  = 1'b0;
        wait (chk0.frames_out == NUM_FRAMES);
        repeat (8) @(posedge clk);
        chk0.final_check(NUM_FRAMES);
        total_errors = chk0.mismatch_count + chk0.other_count + dut0.sva0.fail_count;
        $display("Errors: %0d byte mismatches, %0d other failures, %0d assertion failures",
                 chk0.mismatch_count, chk0.other_count, dut0.sva0.fail_count);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Downstream receiver, hands back one credit per received byte at about half rate
    initial begin
        int owed;
        int quiet;
        owed  = 0;
        quiet = 0;
        forever begin
            @(posedge clk);
            if (out_valid === 1'b1) begin
                owed++;
            end
            #2;
            out_credit = 1'b0;
            if (quiet > 0) begin
                quiet--; // Long stall, output side runs dry
            end else if ($unsigned($random(seed)) % 64 == 0) begin
                quiet = 30;
            end else if (owed > 0 && $random(seed) % 2 == 0) begin
                out_credit = 1'b1;
                owed--;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: not all %0d frames left the DUT within %0d ns", NUM_FRAMES, TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/eth_crc_pkg.sv
rtl/eth_frame_pkg.sv
rtl/byte_stream_if.sv
rtl/eth_ingress_fifo.sv
rtl/eth_pad_insert.sv
rtl/eth_fcs_gen.sv
rtl/eth_fcs_append.sv
rtl/eth_tx_fcs_top.sv
testbench/eth_tx_fcs_sva.sv
testbench/eth_tx_fcs_checker.sv
testbench/eth_tx_fcs_tb.sv
